/* logic/lane_beat_if.sv */
/*
 * Shuffled beat from shuffler to lane buffer, with the buffer empty level
 */
`timescale 1ns/10ps
`default_nettype none

interface lane_beat_if;

  // Capture strobe, only issued while empty
  logic                                                load;
  shf_pkg::lane_data_t [shf_pkg::NR_LANES-1:0]         data;
  shf_pkg::lane_nbe_t  [shf_pkg::NR_LANES-1:0]         nbe;
  shf_pkg::req_id_t                                    req_id;
  shf_pkg::maddr_set_t                                 maddr_set;
  shf_pkg::maddr_bank_t                                maddr_bank;
  // No lane holds a beat
  logic                                                empty;

  modport shuffler (
    output load, data, nbe, req_id, maddr_set, maddr_bank,
    input  empty
  );

  modport outbuf (
    input  load, data, nbe, req_id, maddr_set, maddr_bank,
    output empty
  );

endinterface

`default_nettype wire

/* logic/lane_out_buf.sv */
/*
 * Per-lane holding registers with independent valid/ready drain
 */
`timescale 1ns/10ps
`default_nettype none

module lane_out_buf (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  lane_beat_if.outbuf                                 beat,
  output logic [shf_pkg::NR_LANES-1:0]                lane_valid_o,
  input  wire logic [shf_pkg::NR_LANES-1:0]           lane_ready_i,
  output shf_pkg::lane_data_t [shf_pkg::NR_LANES-1:0] lane_data_o,
  output shf_pkg::lane_nbe_t  [shf_pkg::NR_LANES-1:0] lane_nbe_o,
  output shf_pkg::req_id_t                            lane_req_id_o,
  output shf_pkg::maddr_set_t                         lane_maddr_set_o,
  output shf_pkg::maddr_bank_t                        lane_maddr_bank_o
);

  logic [shf_pkg::NR_LANES-1:0] valid_q;

  assign beat.empty   = !(|valid_q);
  assign lane_valid_o = valid_q;

  // Load only arrives while empty, so no clear collides with it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (beat.load) begin
      valid_q <= '1;
    end else begin
      // Each lane drops on its own handshake
      valid_q <= valid_q & ~lane_ready_i;
    end
  end

  // Payload held until the next load
  always_ff @(posedge clk_i) begin
    if (beat.load) begin
      lane_data_o       <= beat.data;
      lane_nbe_o        <= beat.nbe;
      lane_req_id_o     <= beat.req_id;
      lane_maddr_set_o  <= beat.maddr_set;
      lane_maddr_bank_o <= beat.maddr_bank;
    end
  end

endmodule

`default_nettype wire

/* logic/seq_to_lane_shuffler.sv */
/*
 * Sequential beat to lane shuffler: handshake and commit control,
 * nibble permutation by element width, masking and done pulse
 */
`timescale 1ns/10ps
`default_nettype none

module seq_to_lane_shuffler (
  input  wire logic                                   seq_valid_i,
  output logic                                        seq_ready_o,
  input  shf_pkg::seq_nb_t                            seq_nb_i,
  input  shf_pkg::seq_en_t                            seq_en_i,
  input  wire logic [shf_pkg::NR_LANES-1:0]           mask_valid_i,
  input  shf_pkg::lane_nbe_t [shf_pkg::NR_LANES-1:0]  mask_bits_i,
  output logic                                        mask_ready_o,
  output shf_pkg::done_vec_t                          done_o,
  shf_info_if.shuffler                                info,
  lane_beat_if.shuffler                               beat
);

  logic commit;
  logic last_beat;

  // ----------------------------------------
  // Handshake and strobes
  // ----------------------------------------
  // Lanes drained, head present, mask available unless unmasked
  assign seq_ready_o = beat.empty && info.info_valid && (info.vm || (|mask_valid_i));
  assign commit      = seq_valid_i && seq_ready_o;
  assign last_beat   = commit && (info.cmt_cnt == '0);

  assign info.commit  = commit;
  assign beat.load    = commit;
  // Mask consumed with each masked beat
  assign mask_ready_o = commit && !info.vm;

  // Beat tag straight from the head entry
  assign beat.req_id     = info.req_id;
  assign beat.maddr_set  = info.maddr_set;
  assign beat.maddr_bank = info.maddr_bank;

  // ----------------------------------------
  // Permutation and enables
  // ----------------------------------------
  always_comb begin : permute
    int unsigned lg;
    int unsigned slot;
    int unsigned k;
    int unsigned src;
    // Element width is 2 << sew nibbles
    lg = int'(info.sew) + 1;
    for (int unsigned l = 0; l < shf_pkg::NR_LANES; l++) begin
      for (int unsigned o = 0; o < shf_pkg::LANE_NIBS; o++) begin
        // Slot within lane and nibble within element
        slot = o >> lg;
        k    = o & ((32'd1 << lg) - 1);
        // Elements go round-robin over the lanes
        src  = ((slot * shf_pkg::NR_LANES + l) << lg) + k;
        // Keeps unused sew code in range
        src  = src % shf_pkg::SEQ_NIBS;
        beat.data[l][o*4 +: 4] = seq_nb_i[src*4 +: 4];
        beat.nbe[l][o]         = seq_en_i[src] && (info.vm || mask_bits_i[l][o]);
      end
    end
  end

  // ----------------------------------------
  // Done pulse
  // ----------------------------------------
  // One-hot at the id on the final beat
  always_comb begin
    done_o = '0;
    if (last_beat) begin
      done_o[info.req_id] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/shf_info_if.sv */
/*
 * Head entry of the shuffle info queue and the commit strobe back to it
 */
`timescale 1ns/10ps
`default_nettype none

interface shf_info_if;

  // Head entry present
  logic                 info_valid;
  shf_pkg::req_id_t     req_id;
  shf_pkg::sew_t        sew;
  logic                 vm;
  shf_pkg::cmt_cnt_t    cmt_cnt;
  shf_pkg::maddr_set_t  maddr_set;
  shf_pkg::maddr_bank_t maddr_bank;
  // One beat taken from the head, only while info_valid
  logic                 commit;

  modport queue (
    output info_valid, req_id, sew, vm, cmt_cnt, maddr_set, maddr_bank,
    input  commit
  );

  modport shuffler (
    input  info_valid, req_id, sew, vm, cmt_cnt, maddr_set, maddr_bank,
    output commit
  );

endinterface

`default_nettype wire

/* logic/shf_info_queue.sv */
/*
 * Shuffle info queue: meta intake, matrix address calculation,
 * four-entry FIFO with per-beat commit countdown at the head
 */
`timescale 1ns/10ps
`default_nettype none

module shf_info_queue (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              meta_valid_i,
  output logic                   meta_ready_o,
  input  shf_pkg::req_id_t       meta_req_id_i,
  input  shf_pkg::sew_t          meta_sew_i,
  input  wire logic              meta_vm_i,
  input  shf_pkg::cmt_cnt_t      meta_cmt_cnt_i,
  input  shf_pkg::md_t           meta_md_i,
  shf_info_if.queue              info
);

  // Entry storage
  shf_pkg::req_id_t     req_id_q     [shf_pkg::SHF_DEPTH];
  shf_pkg::sew_t        sew_q        [shf_pkg::SHF_DEPTH];
  logic                 vm_q         [shf_pkg::SHF_DEPTH];
  shf_pkg::cmt_cnt_t    cmt_cnt_q    [shf_pkg::SHF_DEPTH];
  shf_pkg::maddr_set_t  maddr_set_q  [shf_pkg::SHF_DEPTH];
  shf_pkg::maddr_bank_t maddr_bank_q [shf_pkg::SHF_DEPTH];

  // Pointers with wrap flag
  shf_pkg::shf_ptr_t wr_ptr_q, rd_ptr_q;
  logic              wr_flag_q, rd_flag_q;

  logic              full, empty;
  logic              enq, deq, step;
  shf_pkg::maddr_t   maddr_calc;

  // ----------------------------------------
  // Status and strobes
  // ----------------------------------------
  // Flags tell full from empty when the pointers meet
  assign empty = (wr_ptr_q == rd_ptr_q) && (wr_flag_q == rd_flag_q);
  assign full  = (wr_ptr_q == rd_ptr_q) && (wr_flag_q != rd_flag_q);

  assign meta_ready_o = !full;
  assign enq          = meta_valid_i && meta_ready_o;
  // Last beat pops, others just step the head
  assign deq          = info.commit && (info.cmt_cnt == '0);
  assign step         = info.commit && (info.cmt_cnt != '0);

  // Base address of the matrix register
  assign maddr_calc = shf_pkg::maddr_t'(meta_md_i * shf_pkg::SETS_PER_MREG);

  // Head view
  assign info.info_valid = !empty;
  assign info.req_id     = req_id_q[rd_ptr_q];
  assign info.sew        = sew_q[rd_ptr_q];
  assign info.vm         = vm_q[rd_ptr_q];
  assign info.cmt_cnt    = cmt_cnt_q[rd_ptr_q];
  assign info.maddr_set  = maddr_set_q[rd_ptr_q];
  assign info.maddr_bank = maddr_bank_q[rd_ptr_q];

  // ----------------------------------------
  // Pointer update
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      wr_flag_q <= 1'b0;
      rd_flag_q <= 1'b0;
    end else begin
      if (enq) begin
        if (wr_ptr_q == shf_pkg::shf_ptr_t'(shf_pkg::SHF_DEPTH - 1)) begin
          wr_ptr_q  <= '0;
          wr_flag_q <= !wr_flag_q;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (deq) begin
        if (rd_ptr_q == shf_pkg::shf_ptr_t'(shf_pkg::SHF_DEPTH - 1)) begin
          rd_ptr_q  <= '0;
          rd_flag_q <= !rd_flag_q;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Entry write and head countdown
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (enq) begin
      req_id_q[wr_ptr_q]     <= meta_req_id_i;
      sew_q[wr_ptr_q]        <= meta_sew_i;
      vm_q[wr_ptr_q]         <= meta_vm_i;
      cmt_cnt_q[wr_ptr_q]    <= meta_cmt_cnt_i;
      // Upper bits select the set, low bits the bank
      maddr_set_q[wr_ptr_q]  <= maddr_calc[shf_pkg::MADDR_BITS-1:shf_pkg::BANK_BITS];
      maddr_bank_q[wr_ptr_q] <= maddr_calc[shf_pkg::BANK_BITS-1:0];
    end
    // Head never equals the write slot while not full
    if (step) begin
      cmt_cnt_q[rd_ptr_q]   <= info.cmt_cnt - 1'b1;
      maddr_set_q[rd_ptr_q] <= info.maddr_set + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/shf_pkg.sv */
/*
 * Widths, typedefs and constants of the matrix load shuffle path
 */
`default_nettype none

package shf_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  // Lane exits and nibbles per lane
  localparam int unsigned NR_LANES  = 4;
  localparam int unsigned LANE_NIBS = 8;
  // Full sequential beat, one nibble enable each
  localparam int unsigned SEQ_NIBS  = 32;

  // Shuffle info queue
  localparam int unsigned SHF_DEPTH = 4;
  localparam int unsigned PTR_BITS  = $clog2(SHF_DEPTH);

  // Matrix register addressing
  localparam int unsigned SETS_PER_MREG = 6;
  localparam int unsigned MADDR_BITS    = 5;
  localparam int unsigned BANK_BITS     = 2;

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [2:0]                      req_id_t;
  // 0: 2 nibbles, 1: 4 nibbles, 2: 8 nibbles
  typedef logic [1:0]                      sew_t;
  // Beats left in a request, minus one
  typedef logic [3:0]                      cmt_cnt_t;
  typedef logic [1:0]                      md_t;
  typedef logic [MADDR_BITS-1:0]           maddr_t;
  typedef logic [MADDR_BITS-BANK_BITS-1:0] maddr_set_t;
  typedef logic [BANK_BITS-1:0]            maddr_bank_t;
  typedef logic [PTR_BITS-1:0]             shf_ptr_t;
  typedef logic [SEQ_NIBS*4-1:0]           seq_nb_t;
  typedef logic [SEQ_NIBS-1:0]             seq_en_t;
  typedef logic [LANE_NIBS*4-1:0]          lane_data_t;
  typedef logic [LANE_NIBS-1:0]            lane_nbe_t;
  // One bit per request id
  typedef logic [7:0]                      done_vec_t;

endpackage

`default_nettype wire

/* logic/shuffle_top.sv */
/*
 * Matrix load shuffle path top: info queue, shuffler, lane buffer
 */
`timescale 1ns/10ps
`default_nettype none

module shuffle_top (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  // Meta request
  input  wire logic                                   meta_valid_i,
  output logic                                        meta_ready_o,
  input  shf_pkg::req_id_t                            meta_req_id_i,
  input  shf_pkg::sew_t                               meta_sew_i,
  input  wire logic                                   meta_vm_i,
  input  shf_pkg::cmt_cnt_t                           meta_cmt_cnt_i,
  input  shf_pkg::md_t                                meta_md_i,
  // Sequential load beat
  input  wire logic                                   seq_valid_i,
  output logic                                        seq_ready_o,
  input  shf_pkg::seq_nb_t                            seq_nb_i,
  input  shf_pkg::seq_en_t                            seq_en_i,
  // Mask
  input  wire logic [shf_pkg::NR_LANES-1:0]           mask_valid_i,
  input  shf_pkg::lane_nbe_t [shf_pkg::NR_LANES-1:0]  mask_bits_i,
  output logic                                        mask_ready_o,
  output shf_pkg::done_vec_t                          done_o,
  // Lane exits
  output logic [shf_pkg::NR_LANES-1:0]                lane_valid_o,
  input  wire logic [shf_pkg::NR_LANES-1:0]           lane_ready_i,
  output shf_pkg::lane_data_t [shf_pkg::NR_LANES-1:0] lane_data_o,
  output shf_pkg::lane_nbe_t  [shf_pkg::NR_LANES-1:0] lane_nbe_o,
  output shf_pkg::req_id_t                            lane_req_id_o,
  output shf_pkg::maddr_set_t                         lane_maddr_set_o,
  output shf_pkg::maddr_bank_t                        lane_maddr_bank_o
);

  // Queue head to shuffler
  shf_info_if  info_if ();
  // Shuffler to lane buffer
  lane_beat_if beat_if ();

  shf_info_queue u_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .meta_valid_i   (meta_valid_i),
    .meta_ready_o   (meta_ready_o),
    .meta_req_id_i  (meta_req_id_i),
    .meta_sew_i     (meta_sew_i),
    .meta_vm_i      (meta_vm_i),
    .meta_cmt_cnt_i (meta_cmt_cnt_i),
    .meta_md_i      (meta_md_i),
    .info           (info_if.queue)
  );

  seq_to_lane_shuffler u_shuffler (
    .seq_valid_i  (seq_valid_i),
    .seq_ready_o  (seq_ready_o),
    .seq_nb_i     (seq_nb_i),
    .seq_en_i     (seq_en_i),
    .mask_valid_i (mask_valid_i),
    .mask_bits_i  (mask_bits_i),
    .mask_ready_o (mask_ready_o),
    .done_o       (done_o),
    .info         (info_if.shuffler),
    .beat         (beat_if.shuffler)
  );

  lane_out_buf u_outbuf (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .beat              (beat_if.outbuf),
    .lane_valid_o      (lane_valid_o),
    .lane_ready_i      (lane_ready_i),
    .lane_data_o       (lane_data_o),
    .lane_nbe_o        (lane_nbe_o),
    .lane_req_id_o     (lane_req_id_o),
    .lane_maddr_set_o  (lane_maddr_set_o),
    .lane_maddr_bank_o (lane_maddr_bank_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the shuffle path testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_shuffle_top -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_shuffle_top +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

/* src.f */
logic/shf_pkg.sv
logic/shf_info_if.sv
logic/lane_beat_if.sv
logic/shf_info_queue.sv
logic/seq_to_lane_shuffler.sv
logic/lane_out_buf.sv
logic/shuffle_top.sv
verif/shuffle_assert.sv
verif/tb_shuffle_top.sv

/* verif/shuffle_assert.sv */
/*
 * Concurrent checks on the shuffle path top: lane hold, drain before
 * accept, done pulse shape and timing
 */
`timescale 1ns/10ps
`default_nettype none

module shuffle_assert (
  input wire logic                                        clk_i,
  input wire logic                                        rst_ni,
  input wire logic                                        seq_valid_i,
  input wire logic                                        seq_ready_i,
  input wire shf_pkg::done_vec_t                          done_i,
  input wire logic [shf_pkg::NR_LANES-1:0]                lane_valid_i,
  input wire logic [shf_pkg::NR_LANES-1:0]                lane_ready_i,
  input wire shf_pkg::lane_data_t [shf_pkg::NR_LANES-1:0] lane_data_i,
  input wire shf_pkg::lane_nbe_t  [shf_pkg::NR_LANES-1:0] lane_nbe_i
);

  // Stalled lane keeps its beat
  for (genvar l = 0; l < shf_pkg::NR_LANES; l++) begin : g_hold
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_valid_i[l] && !lane_ready_i[l] |=>
        lane_valid_i[l] && $stable(lane_data_i[l]) && $stable(lane_nbe_i[l]))
      else $error("lane %0d lost or changed its beat while stalled", l);
  end

  a_drained: assert property (@(posedge clk_i) disable iff (!rst_ni)
    seq_ready_i |-> lane_valid_i == '0)
    else $error("seq ready while a lane still holds a beat");

  a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(done_i))
    else $error("done vector has more than one bit set");

  // Done only with the final beat transfer
  a_done_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i != '0 |-> seq_valid_i && seq_ready_i)
    else $error("done pulse outside a seq transfer");

endmodule

`default_nettype wire

/* verif/tb_shuffle_top.sv */
/*
 * Testbench for the shuffle path top: clock, reset, meta and beat stimulus,
 * reference model of permutation and addressing, and a compare process
 */
`timescale 1ns/10ps
`default_nettype none

module tb_shuffle_top;

  localparam int N_BEATS    = 32;
  localparam int TIMEOUT_NS = (N_BEATS * 40 + 200) * 20;

  // Model entry of one pending request
  typedef struct packed {
    shf_pkg::req_id_t  id;
    shf_pkg::sew_t     sew;
    logic              vm;
    shf_pkg::cmt_cnt_t cnt;
    shf_pkg::md_t      md;
  } meta_t;

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        meta_valid_i;
  logic                                        meta_ready_o;
  shf_pkg::req_id_t                            meta_req_id_i;
  shf_pkg::sew_t                               meta_sew_i;
  logic                                        meta_vm_i;
  shf_pkg::cmt_cnt_t                           meta_cmt_cnt_i;
  shf_pkg::md_t                                meta_md_i;
  logic                                        seq_valid_i;
  logic                                        seq_ready_o;
  shf_pkg::seq_nb_t                            seq_nb_i;
  shf_pkg::seq_en_t                            seq_en_i;
  logic [shf_pkg::NR_LANES-1:0]                mask_valid_i;
  shf_pkg::lane_nbe_t [shf_pkg::NR_LANES-1:0]  mask_bits_i;
  logic                                        mask_ready_o;
  shf_pkg::done_vec_t                          done_o;
  logic [shf_pkg::NR_LANES-1:0]                lane_valid_o;
  logic [shf_pkg::NR_LANES-1:0]                lane_ready_i;
  shf_pkg::lane_data_t [shf_pkg::NR_LANES-1:0] lane_data_o;
  shf_pkg::lane_nbe_t  [shf_pkg::NR_LANES-1:0] lane_nbe_o;
  shf_pkg::req_id_t                            lane_req_id_o;
  shf_pkg::maddr_set_t                         lane_maddr_set_o;
  shf_pkg::maddr_bank_t                        lane_maddr_bank_o;

  // Scoreboard state
  logic                bp_en;
  int                  errors;
  int                  seq_beats;
  int                  lane_hits;
  int                  head_beat;
  meta_t               model_q[$];
  logic [3:0]          pending;
  shf_pkg::lane_data_t exp_data [shf_pkg::NR_LANES];
  shf_pkg::lane_nbe_t  exp_nbe  [shf_pkg::NR_LANES];
  shf_pkg::req_id_t    exp_id;
  logic [4:0]          exp_addr;

  shuffle_top UUT (.*);

  bind shuffle_top shuffle_assert u_assert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seq_valid_i  (seq_valid_i),
    .seq_ready_i  (seq_ready_o),
    .done_i       (done_o),
    .lane_valid_i (lane_valid_o),
    .lane_ready_i (lane_ready_i),
    .lane_data_i  (lane_data_o),
    .lane_nbe_i   (lane_nbe_o)
  );

  always #10 clk_i = ~clk_i;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Data in [39:8] and nibble enables in [7:0]
  function automatic logic [39:0] expected_lane(input shf_pkg::seq_nb_t nb,
      input shf_pkg::seq_en_t en, input shf_pkg::lane_nbe_t mask, input logic vm,
      input shf_pkg::sew_t sew, input int lane);
    int          w;
    int          o;
    int          src;
    logic [31:0] data;
    logic [7:0]  nbe;
    w = 2 << int'(sew);
    for (o = 0; o < 8; o++) begin
      // Element (slot, lane) round-robin, then nibble within element
      src              = ((o / w) * 4 + lane) * w + (o % w);
      data[o*4 +: 4]   = nb[src*4 +: 4];
      nbe[o]           = en[src] & (vm | mask[o]);
    end
    return {data, nbe};
  endfunction

  // Set in [4:2] and bank in [1:0]
  function automatic logic [4:0] expected_addr(input shf_pkg::md_t md, input int beat);
    int base;
    base = int'(md) * 6;
    return {3'(base / 4 + beat), 2'(base % 4)};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
      input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(posedge clk_i) begin : compare
    logic               seq_xfer;
    logic [39:0]        ref_lane;
    meta_t              head;
    shf_pkg::done_vec_t exp_done;
    int                 l;
    if (rst_ni) begin
      seq_xfer = seq_valid_i && seq_ready_o;
      head     = (model_q.size() > 0) ? model_q[0] : meta_t'(0);
      // Handshake levels against the model
      compare_value("meta_ready_o", meta_ready_o, model_q.size() < 4);
      compare_value("seq_ready_o", seq_ready_o,
                    pending == 0 && model_q.size() > 0 && (head.vm || |mask_valid_i));
      compare_value("lane_valid_o", lane_valid_o, pending);
      compare_value("mask_ready_o", mask_ready_o, seq_xfer && !head.vm);
      exp_done = '0;
      if (seq_xfer && head_beat == int'(head.cnt)) begin
        exp_done[head.id] = 1'b1;
      end
      compare_value("done_o", done_o, exp_done);
      // Lane deliveries
      for (l = 0; l < 4; l++) begin
        if (lane_valid_o[l] && lane_ready_i[l]) begin
          compare_value($sformatf("lane_data_o[%0d]", l), lane_data_o[l], exp_data[l]);
          compare_value($sformatf("lane_nbe_o[%0d]", l), lane_nbe_o[l], exp_nbe[l]);
          compare_value("lane_req_id_o", lane_req_id_o, exp_id);
          compare_value("lane_maddr_set_o", lane_maddr_set_o, exp_addr[4:2]);
          compare_value("lane_maddr_bank_o", lane_maddr_bank_o, exp_addr[1:0]);
          pending[l] = 1'b0;
          lane_hits++;
        end
      end
      // New beat from the head request
      if (seq_xfer && model_q.size() > 0) begin
        for (l = 0; l < 4; l++) begin
          ref_lane    = expected_lane(seq_nb_i, seq_en_i, mask_bits_i[l], head.vm,
                                      head.sew, l);
          exp_data[l] = ref_lane[39:8];
          exp_nbe[l]  = ref_lane[7:0];
        end
        exp_id   = head.id;
        exp_addr = expected_addr(head.md, head_beat);
        pending  = '1;
        seq_beats++;
        if (head_beat == int'(head.cnt)) begin
          void'(model_q.pop_front());
          head_beat = 0;
        end else begin
          head_beat++;
        end
      end
      if (meta_valid_i && meta_ready_o) begin
        model_q.push_back({meta_req_id_i, meta_sew_i, meta_vm_i, meta_cmt_cnt_i, meta_md_i});
      end
    end
  end

  // Lane consumers with random stalls when enabled
  always @(posedge clk_i) begin
    #2;
    lane_ready_i = bp_en ? 4'($urandom) : '1;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic send_meta(input int id, input int sew, input logic vm, input int cnt,
      input int md);
    meta_valid_i   = 1'b1;
    meta_req_id_i  = 3'(id);
    meta_sew_i     = 2'(sew);
    meta_vm_i      = vm;
    meta_cmt_cnt_i = 4'(cnt);
    meta_md_i      = 2'(md);
    do @(posedge clk_i); while (!meta_ready_o);
    #2;
    meta_valid_i = 1'b0;
  endtask

  // Mask held back for stall cycles first
  task automatic send_beat(input logic [3:0] mvalid, input int stall);
    seq_nb_i     = {$urandom, $urandom, $urandom, $urandom};
    seq_en_i     = $urandom;
    mask_bits_i  = $urandom;
    mask_valid_i = (stall > 0) ? '0 : mvalid;
    seq_valid_i  = 1'b1;
    if (stall > 0) begin
      repeat (stall) @(posedge clk_i);
      #2;
      mask_valid_i = mvalid;
    end
    do @(posedge clk_i); while (!seq_ready_o);
    #2;
    seq_valid_i  = 1'b0;
    mask_valid_i = '0;
  endtask

  initial begin : stimulus
    int          s;
    void'($urandom(32'h936d));
    {clk_i, rst_ni, meta_valid_i, seq_valid_i, bp_en} = '0;
    {meta_req_id_i, meta_sew_i, meta_vm_i, meta_cmt_cnt_i, meta_md_i} = '0;
    {seq_nb_i, seq_en_i, mask_valid_i, mask_bits_i} = '0;
    lane_ready_i = '1;
    {errors, seq_beats, lane_hits, head_beat} = '0;
    pending = '0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Unmasked permutation for each element width
    for (s = 0; s < 3; s++) begin
      send_meta(s, s, 1'b1, 3, s);
      repeat (4) send_beat(4'b0000, 0);
    end
    // Masked beats where the first one waits for a mask
    send_meta(4, 1, 1'b0, 3, 1);
    for (s = 0; s < 4; s++) begin
      send_beat(4'b0001 << s, (s == 0) ? 3 : 0);
    end
    // Four beats on one request with a nonzero bank
    send_meta(5, 2, 1'b1, 3, 3);
    repeat (4) send_beat(4'b0000, 0);
    // Lane back-pressure
    bp_en = 1'b1;
    send_meta(6, 0, 1'b0, 7, 2);
    repeat (8) send_beat(4'b1000, 0);
    bp_en = 1'b0;
    // Fill the queue, then drain in order
    for (s = 0; s < 4; s++) begin
      send_meta(7 - s, s % 3, 1'b1, 0, s);
    end
    @(posedge clk_i);
    #2;
    compare_value("meta_ready_o", meta_ready_o, 1'b0);
    send_beat(4'b0000, 0);
    compare_value("meta_ready_o", meta_ready_o, 1'b1);
    repeat (3) send_beat(4'b0000, 0);
    while (lane_valid_o != '0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    compare_value("accepted beats", seq_beats, N_BEATS);
    compare_value("lane deliveries", lane_hits, N_BEATS * 4);
    $display("Check errors: %0d, beats: %0d, lane deliveries: %0d",
             errors, seq_beats, lane_hits);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
